//--- Bender.yml
package:
  name: tcdm_user

export_include_dirs:
  - design

sources:
  - design/tcdm_pkg.sv
  - design/tcdm_r_user_filter.sv
  - design/tcdm_req_router.sv
  - design/tcdm_sram_bank.sv
  - design/tcdm_rsp_router.sv
  - design/tcdm_subsystem.sv
  - target: test
    files:
      - dv/tcdm_clk_gen.sv
      - dv/tcdm_properties.sv
      - dv/tcdm_checker.sv
      - dv/tcdm_tb.sv

//--- design/tcdm_cfg.svh
/*
  Geometry of the shared scratchpad: address, data and user widths, bank count
  and depth, and the word-interleaved address map derived from them.
  Include this wherever a width or bank count is needed.
*/
`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

`define TCDM_AW         32  // byte address width.
`define TCDM_DW         32  // data word width.
`define TCDM_UW         8   // user tag width.
`define TCDM_NB_BANKS   2   // word-interleaved banks.
`define TCDM_BANK_WORDS 64  // words per bank.
`define TCDM_NB_INIT    2   // initiator ports.

`define TCDM_BE_W     (`TCDM_DW / 8)                // one enable per byte.
`define TCDM_BANK_LSB ($clog2(`TCDM_BE_W))          // first bit above the byte offset.
`define TCDM_BANK_W   ($clog2(`TCDM_NB_BANKS))      // bank select bits.
`define TCDM_ROW_W    ($clog2(`TCDM_BANK_WORDS))    // row bits inside a bank.
`define TCDM_ROW_LSB  (`TCDM_BANK_LSB + `TCDM_BANK_W)  // row sits right above bank select.

`endif

//--- design/tcdm_pkg.sv
/*
  Bundles shared by the scratchpad blocks: the initiator request, the
  response returned to an initiator, and one bank's access after routing.
*/
`include "tcdm_cfg.svh"

package tcdm_pkg;

  // request as issued by an initiator; wen high means read.
  typedef struct packed {
    logic                  req;   // request strobe, held until granted.
    logic [`TCDM_AW-1:0]   add;   // byte address.
    logic                  wen;   // 1 = read, 0 = write.
    logic [`TCDM_BE_W-1:0] be;    // byte enables for writes.
    logic [`TCDM_DW-1:0]   data;  // write data.
    logic [`TCDM_UW-1:0]   user;  // tag echoed back as r_user.
  } tcdm_req_t;

  // response, one cycle after a granted read.
  typedef struct packed {
    logic                r_valid;  // read data valid.
    logic [`TCDM_DW-1:0] r_data;   // read data.
    logic [`TCDM_UW-1:0] r_user;   // tag of the request that produced it.
  } tcdm_rsp_t;

  // access driven into one bank by the request router.
  typedef struct packed {
    logic                   csn;    // chip select, active low.
    logic                   wen;    // 1 = read, 0 = write.
    logic [`TCDM_BE_W-1:0]  be;     // byte enables.
    logic [`TCDM_ROW_W-1:0] row;    // word index in the bank.
    logic [`TCDM_DW-1:0]    wdata;  // write data.
  } bank_req_t;

  // 78 + 41 + 44 bits with the default geometry.

endpackage

//--- design/tcdm_r_user_filter.sv
/*
  User-tag filter for one initiator port. Strips the user field from the
  request going downstream and returns the captured tag as r_user.
  Only valid where a granted read is answered exactly one cycle later.
*/
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_r_user_filter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,   // zero the held tag.
  input  logic                enable_i,  // allow tag capture.
  input  tcdm_pkg::tcdm_req_t tgt_req,   // from the initiator.
  output logic                tgt_gnt,
  output tcdm_pkg::tcdm_rsp_t tgt_rsp,
  output tcdm_pkg::tcdm_req_t init_req,  // towards the request router.
  input  logic                init_gnt,
  input  tcdm_pkg::tcdm_rsp_t init_rsp
);

  logic [`TCDM_UW-1:0] user_q;  // tag of the latest request.

  // downstream never sees the tag.
  always_comb begin
    init_req      = tgt_req;
    init_req.user = '0;
  end

  assign tgt_gnt = init_gnt;

  // tag comes from the register, everything else passes up.
  always_comb begin
    tgt_rsp        = init_rsp;
    tgt_rsp.r_user = user_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear_i) begin
      user_q <= '0;  // clear wins over capture.
    end else if (enable_i && tgt_req.req) begin
      user_q <= tgt_req.user;
    end
  end

endmodule

//--- design/tcdm_req_router.sv
/*
  Decode stage of the scratchpad. Splits each request address into bank and
  row, arbitrates every bank round-robin between the two initiators and
  drives the winner into the bank. Grants are combinational with req.
*/
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_req_router (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  tcdm_pkg::tcdm_req_t        req         [`TCDM_NB_INIT],
  output logic [`TCDM_NB_INIT-1:0]   gnt,
  output tcdm_pkg::bank_req_t        bank_req    [`TCDM_NB_BANKS],
  output logic [`TCDM_NB_BANKS-1:0]  owner,        // granted initiator per bank.
  output logic [`TCDM_NB_BANKS-1:0]  owner_valid   // bank serves a read this cycle.
);

  logic [`TCDM_BANK_W-1:0]  bank_sel [`TCDM_NB_INIT];   // decoded bank per initiator.
  logic [`TCDM_ROW_W-1:0]   row      [`TCDM_NB_INIT];   // decoded row per initiator.
  logic [`TCDM_NB_INIT-1:0] want     [`TCDM_NB_BANKS];  // initiators asking for each bank.
  logic [`TCDM_NB_BANKS-1:0] contest;                   // both initiators on one bank.
  logic [`TCDM_NB_BANKS-1:0] rr_q;                      // favoured initiator per bank.

  // address map is word interleaved.
  always_comb begin
    for (int i = 0; i < `TCDM_NB_INIT; i++) begin
      bank_sel[i] = req[i].add[`TCDM_BANK_LSB +: `TCDM_BANK_W];  // bit 2.
      row[i]      = req[i].add[`TCDM_ROW_LSB +: `TCDM_ROW_W];    // bits 8..3.
    end
  end

  always_comb begin
    gnt = '0;
    for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
      for (int i = 0; i < `TCDM_NB_INIT; i++) begin
        want[b][i] = req[i].req && (bank_sel[i] == `TCDM_BANK_W'(b));
      end
      contest[b] = &want[b];
      // pointer decides a tie, otherwise the only requester wins.
      owner[b] = contest[b] ? rr_q[b] : want[b][1];
      gnt[owner[b]] = gnt[owner[b]] | (|want[b]);
      owner_valid[b] = (|want[b]) && req[owner[b]].wen;  // writes get no response.
      bank_req[b].csn   = ~(|want[b]);
      bank_req[b].wen   = req[owner[b]].wen;
      bank_req[b].be    = req[owner[b]].be;
      bank_req[b].row   = row[owner[b]];
      bank_req[b].wdata = req[owner[b]].data;
    end
  end

  // a contested grant hands the next tie to the loser.
  // with two initiators that is a toggle of the pointer.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;  // initiator 0 favoured after reset.
    end else begin
      rr_q <= rr_q ^ contest;
    end
  end

endmodule

//--- design/tcdm_rsp_router.sv
/*
  Result stage of the scratchpad. Records which initiator each bank served
  on a read and, in the next cycle, returns that bank's data to it.
  r_user is left zero here, the user filter fills it in.
*/
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_rsp_router (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`TCDM_NB_BANKS-1:0] owner,        // granted initiator per bank.
  input  logic [`TCDM_NB_BANKS-1:0] owner_valid,  // bank granted a read.
  input  logic [`TCDM_DW-1:0]       rdata [`TCDM_NB_BANKS],
  output tcdm_pkg::tcdm_rsp_t       rsp   [`TCDM_NB_INIT]
);

  logic [`TCDM_NB_BANKS-1:0] owner_q;        // initiator served last cycle.
  logic [`TCDM_NB_BANKS-1:0] owner_valid_q;  // a read is due from the bank.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q       <= '0;
      owner_valid_q <= '0;  // no response right after reset.
    end else begin
      owner_q       <= owner;
      owner_valid_q <= owner_valid;
    end
  end

  // an initiator holds at most one grant per cycle,
  // so at most one bank matches it here
  always_comb begin
    for (int i = 0; i < `TCDM_NB_INIT; i++) begin
      rsp[i] = '0;
      for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
        if (owner_valid_q[b] && (owner_q[b] == 1'(i))) begin
          rsp[i].r_valid = 1'b1;
          rsp[i].r_data  = rdata[b];
        end
      end
    end
  end

endmodule

//--- design/tcdm_sram_bank.sv
/*
  Execute stage of the scratchpad: one single-port SRAM bank. Writes update
  only the enabled bytes; reads return the word on rdata one cycle later.
  rdata holds its value between reads.
*/
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_sram_bank (
  input  logic                clk_i,
  input  tcdm_pkg::bank_req_t bank_req,
  output logic [`TCDM_DW-1:0] rdata
);

  logic [`TCDM_DW-1:0] mem [`TCDM_BANK_WORDS];  // storage array.
  logic                wr_en;                   // selected write.
  logic                rd_en;                   // selected read.

  assign wr_en = !bank_req.csn && !bank_req.wen;
  assign rd_en = !bank_req.csn &&  bank_req.wen;

  // byte-granular write; disabled bytes keep their contents.
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < `TCDM_BE_W; i++) begin
        if (bank_req.be[i]) begin
          mem[bank_req.row][8*i +: 8] <= bank_req.wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read, one cycle latency.
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata <= mem[bank_req.row];
    end
  end

endmodule

//--- design/tcdm_subsystem.sv
/*
  Shared scratchpad top: two initiator ports, each behind a user filter,
  reach the word-interleaved banks through the request and response routers.
  Reads answer one cycle after the grant; writes give no response.
*/
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_subsystem (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     enable_i,
  input  tcdm_pkg::tcdm_req_t      req_i [`TCDM_NB_INIT],
  output logic [`TCDM_NB_INIT-1:0] gnt_o,
  output tcdm_pkg::tcdm_rsp_t      rsp_o [`TCDM_NB_INIT]
);
  import tcdm_pkg::*;

  tcdm_req_t                 filt_req   [`TCDM_NB_INIT];   // requests with user stripped.
  logic [`TCDM_NB_INIT-1:0]  filt_gnt;                     // router grants.
  tcdm_rsp_t                 filt_rsp   [`TCDM_NB_INIT];   // routed responses.
  bank_req_t                 bank_req   [`TCDM_NB_BANKS];  // per-bank access.
  logic [`TCDM_NB_BANKS-1:0] gnt_q_owner;                  // winner per bank.
  logic [`TCDM_NB_BANKS-1:0] gnt_q_valid;                  // winner reads.
  logic [`TCDM_DW-1:0]       bank_rdata [`TCDM_NB_BANKS];  // bank read data.

  for (genvar k = 0; k < `TCDM_NB_INIT; k++) begin : gen_filter
    tcdm_r_user_filter u_filter (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .clear_i  (clear_i),
      .enable_i (enable_i),
      .tgt_req  (req_i[k]),
      .tgt_gnt  (gnt_o[k]),
      .tgt_rsp  (rsp_o[k]),
      .init_req (filt_req[k]),
      .init_gnt (filt_gnt[k]),
      .init_rsp (filt_rsp[k])
    );
  end

  tcdm_req_router u_req_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req         (filt_req),
    .gnt         (filt_gnt),
    .bank_req    (bank_req),
    .owner       (gnt_q_owner),
    .owner_valid (gnt_q_valid)
  );

  for (genvar b = 0; b < `TCDM_NB_BANKS; b++) begin : gen_bank
    tcdm_sram_bank u_bank (
      .clk_i    (clk_i),
      .bank_req (bank_req[b]),
      .rdata    (bank_rdata[b])
    );
  end

  tcdm_rsp_router u_rsp_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .owner       (gnt_q_owner),
    .owner_valid (gnt_q_valid),
    .rdata       (bank_rdata),
    .rsp         (filt_rsp)
  );

endmodule

//--- dv/tcdm_checker.sv
/*
  Reference model and scoreboard for the scratchpad. Predicts grants with the
  round-robin rule, keeps a byte image of the banks and the captured tags, and
  compares gnt_o and both responses at every rising edge.
*/
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_checker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     enable_i,
  input  tcdm_pkg::tcdm_req_t      req_i [`TCDM_NB_INIT],
  input  logic [`TCDM_NB_INIT-1:0] gnt_o,
  input  tcdm_pkg::tcdm_rsp_t      rsp_o [`TCDM_NB_INIT],
  output int                       err_cnt [4]  // gnt_o, r_valid, r_data, r_user.
);
  import tcdm_pkg::*;

  logic [7:0]                mem_model [512];           // bytes at address bits 8..0.
  logic [`TCDM_NB_BANKS-1:0] rr;                        // favoured initiator per bank.
  logic [`TCDM_NB_INIT-1:0]  exp_gnt;
  logic [`TCDM_NB_INIT-1:0]  exp_valid;                 // response due this cycle.
  logic [`TCDM_DW-1:0]       exp_data [`TCDM_NB_INIT];
  logic [`TCDM_UW-1:0]       exp_user [`TCDM_NB_INIT];  // mirrors the filter tag.

  task automatic compare(input int idx, input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt[idx]++;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    logic [`TCDM_NB_INIT-1:0] want;
    logic [8:0]               addr;
    int                       win;
    if (!rst_ni) begin
      rr        = '0;  // initiator 0 first.
      exp_valid = '0;
      exp_user  = '{default: '0};
    end else begin
      for (int k = 0; k < `TCDM_NB_INIT; k++) begin
        compare(1, $sformatf("rsp_o[%0d].r_valid", k), 32'(rsp_o[k].r_valid),
                32'(exp_valid[k]));
        if (exp_valid[k]) begin
          compare(2, $sformatf("rsp_o[%0d].r_data", k), rsp_o[k].r_data, exp_data[k]);
        end
        compare(3, $sformatf("rsp_o[%0d].r_user", k), 32'(rsp_o[k].r_user),
                32'(exp_user[k]));  // tag shows every cycle.
      end
      exp_gnt = '0;
      for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
        for (int k = 0; k < `TCDM_NB_INIT; k++) begin
          want[k] = req_i[k].req && (req_i[k].add[2] == 1'(b));  // bit 2 picks the bank.
        end
        win = (&want) ? int'(rr[b]) : int'(want[1]);
        if (&want) rr[b] = (win == 0);  // the loser is favoured next.
        if (|want) exp_gnt[win] = 1'b1;
      end
      compare(0, "gnt_o", 32'(gnt_o), 32'(exp_gnt));
      // one bank per grant, so the reads and writes below never overlap.
      for (int k = 0; k < `TCDM_NB_INIT; k++) begin
        exp_valid[k] = exp_gnt[k] && req_i[k].wen;
        for (int j = 0; j < `TCDM_BE_W; j++) begin
          addr = {req_i[k].add[8:2], 2'(j)};
          if (exp_valid[k]) begin
            exp_data[k][8*j +: 8] = mem_model[addr];
          end else if (exp_gnt[k] && req_i[k].be[j]) begin
            mem_model[addr] = req_i[k].data[8*j +: 8];  // enabled bytes only.
          end
        end
        if (clear_i) begin
          exp_user[k] = '0;
        end else if (enable_i && req_i[k].req) begin
          exp_user[k] = req_i[k].user;  // captured granted or not.
        end
      end
    end
  end

endmodule

//--- dv/tcdm_clk_gen.sv
/*
  Testbench clock and reset: 8 ns clock, reset held low for 10 cycles
  and released on a falling edge.
*/
`timescale 1ns/1ps

module tcdm_clk_gen (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period.
  end

  initial begin
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;  // away from the sampling edge.
  end

endmodule

//--- dv/tcdm_properties.sv
/*
  Assertions bound into every user filter. They check the one-cycle boundary
  that the filter relies on: a granted read answers next cycle, nothing else does.
*/
`timescale 1ns/1ps

module tcdm_properties (
  input logic                clk_i,
  input logic                rst_ni,
  input tcdm_pkg::tcdm_req_t tgt_req,
  input logic                tgt_gnt,
  input tcdm_pkg::tcdm_rsp_t tgt_rsp
);

  logic rd_gnt;  // read granted on this port.

  assign rd_gnt = tgt_req.req && tgt_gnt && tgt_req.wen;

  a_read_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_gnt |=> tgt_rsp.r_valid)
    else $error("granted read got no response in the next cycle");

  // writes and idle cycles are both silent one cycle later.
  a_no_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_gnt |=> !tgt_rsp.r_valid)
    else $error("response seen without a read grant in the previous cycle");

endmodule

bind tcdm_r_user_filter tcdm_properties u_properties (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .tgt_req  (tgt_req),
  .tgt_gnt  (tgt_gnt),
  .tgt_rsp  (tgt_rsp)
);

//--- dv/tcdm_tb.sv
/*
  Testbench top for the scratchpad. Applies a table of per-cycle requests on
  falling edges and holds each ungranted request until it is granted. The
  checker does the comparing; a watchdog bounds the run.
*/
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_tb;
  import tcdm_pkg::*;

  localparam logic RD = 1'b1;
  localparam logic WR = 1'b0;

  typedef struct packed {
    tcdm_req_t [`TCDM_NB_INIT-1:0] req;  // one request per initiator.
    logic                          en;   // enable_i for the row.
    logic                          clr;  // clear_i pulse.
  } row_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     clear_i;
  logic                     enable_i;
  tcdm_req_t                req_i [`TCDM_NB_INIT];
  logic [`TCDM_NB_INIT-1:0] gnt_o;
  tcdm_rsp_t                rsp_o [`TCDM_NB_INIT];
  int                       err_cnt [4];
  int                       total;
  int                       seed;
  row_t                     stim_q [$];
  logic [`TCDM_NB_INIT-1:0] pending;  // still waiting for a grant.

  tcdm_clk_gen u_clk_gen (.clk_i(clk_i), .rst_ni(rst_ni));

  tcdm_subsystem u_dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .enable_i (enable_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .rsp_o    (rsp_o)
  );

  tcdm_checker u_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .enable_i (enable_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .rsp_o    (rsp_o),
    .err_cnt  (err_cnt)
  );

  // random write data and tag.
  function automatic tcdm_req_t make_req(input logic rd, input logic [8:0] a,
                                         input logic [3:0] be = 4'hf);
    tcdm_req_t r;
    r      = '0;
    r.req  = 1'b1;
    r.add  = `TCDM_AW'(a);
    r.wen  = rd;
    r.be   = be;
    r.data = `TCDM_DW'($random(seed));
    r.user = `TCDM_UW'($random(seed));
    return r;
  endfunction

  function automatic void add_row(input tcdm_req_t r0, input tcdm_req_t r1,
                                  input logic en = 1'b1, input logic clr = 1'b0);
    row_t row;
    row.req[0] = r0;
    row.req[1] = r1;
    row.en     = en;
    row.clr    = clr;
    stim_q.push_back(row);
  endfunction

  task automatic build_stimulus();
    // full writes in both banks, then partial ones.
    add_row(make_req(WR, 9'h000), make_req(WR, 9'h004));
    add_row(make_req(WR, 9'h008), make_req(WR, 9'h01c));
    add_row(make_req(WR, 9'h010), make_req(WR, 9'h000, 4'h5));
    add_row(make_req(WR, 9'h004, 4'h8), '0);
    add_row(make_req(RD, 9'h000), '0);
    add_row('0, make_req(RD, 9'h004));
    add_row(make_req(RD, 9'h01c), make_req(RD, 9'h008));  // different banks.
    for (int i = 0; i < 3; i++) begin
      add_row(make_req(RD, 9'h000), make_req(RD, 9'h010));  // both on bank 0.
    end
    add_row(make_req(WR, 9'h010, 4'h3), make_req(RD, 9'h008));
    add_row(make_req(RD, 9'h010), make_req(WR, 9'h010, 4'hc));
    for (int i = 0; i < 4; i++) begin
      add_row(make_req(RD, 9'h004), make_req(RD, 9'h000));  // new tag each row.
    end
    // tag held with capture off, cleared, then captured again.
    add_row(make_req(RD, 9'h008), make_req(RD, 9'h01c), 1'b0);
    add_row('0, '0, 1'b0, 1'b1);
    add_row(make_req(RD, 9'h000), make_req(RD, 9'h004), 1'b0);
    add_row(make_req(RD, 9'h010), '0);
    add_row(make_req(WR, 9'h020), make_req(WR, 9'h024));
    add_row('0, '0);
    add_row(make_req(RD, 9'h024), make_req(RD, 9'h020));
  endtask

  initial begin
    seed     = 33;
    clear_i  = 1'b0;
    enable_i = 1'b0;
    foreach (req_i[k]) req_i[k] = '0;
    build_stimulus();
    @(posedge rst_ni);
    foreach (stim_q[r]) begin
      @(negedge clk_i);
      enable_i = stim_q[r].en;
      clear_i  = stim_q[r].clr;
      for (int k = 0; k < `TCDM_NB_INIT; k++) begin
        req_i[k]   = stim_q[r].req[k];
        pending[k] = stim_q[r].req[k].req;
      end
      @(posedge clk_i);
      pending = pending & ~gnt_o;
      // a stalled initiator keeps its request, a served one goes idle.
      while (pending != '0) begin
        @(negedge clk_i);
        clear_i = 1'b0;
        for (int k = 0; k < `TCDM_NB_INIT; k++) req_i[k].req = pending[k];
        @(posedge clk_i);
        pending = pending & ~gnt_o;
      end
    end
    @(negedge clk_i);
    foreach (req_i[k]) req_i[k] = '0;
    repeat (2) @(posedge clk_i);  // last response gets compared.
    @(negedge clk_i);
    total = err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3];
    $display("errors: gnt_o %0d, r_valid %0d, r_data %0d, r_user %0d, total %0d",
             err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], total);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // each row needs at most two cycles, four leaves room for the drain.
  initial begin
    @(posedge rst_ni);
    repeat (4 * stim_q.size()) @(posedge clk_i);
    $display("timeout: stimulus table not finished after %0d cycles", 4 * stim_q.size());
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- tcdm_user.f
+incdir+design
design/tcdm_pkg.sv
design/tcdm_r_user_filter.sv
design/tcdm_req_router.sv
design/tcdm_sram_bank.sv
design/tcdm_rsp_router.sv
design/tcdm_subsystem.sv
dv/tcdm_clk_gen.sv
dv/tcdm_properties.sv
dv/tcdm_checker.sv
dv/tcdm_tb.sv
